// ==== testbench/phoenix_tests.txt ====
# H chip1 chip2 (9-bit hex, bit 0 = h up to bit 8 = ser) | E enc_a enc_b sw_flt_n (hex)
# G stop_len sleep_len (decimal cycles) | C control word (hex) | P motor(0-3) duty_a duty_b duty_c
H 0f0 10f
H 155 0aa
E 5 a 1b
H 1ff 000
E c 3 15
G 50 200
G 200 50
C c15
C 2b3
P 0 0064 00f5 00c8
P 1 0000 00f6 ffff
P 2 007d 0001 00f4
P 3 00fa 0080 00f5
C 8b3
C 2b3
P 1 0032 0096 00c8

// ==== filelist.f ====
hw/phoenix_pkg.sv
hw/hall_sr_reader.sv
hw/input_deglitch.sv
hw/pwm_phase_driver.sv
hw/board_io_regs.sv
hw/phoenix_top.sv
testbench/phoenix_assert.sv
testbench/phoenix_tb.sv

// ==== Bender.yml ====
package:
  name: phoenix_board_io

sources:
  - files:
      - hw/phoenix_pkg.sv
      - hw/hall_sr_reader.sv
      - hw/input_deglitch.sv
      - hw/pwm_phase_driver.sv
      - hw/board_io_regs.sv
      - hw/phoenix_top.sv
  - target: test
    files:
      - testbench/phoenix_assert.sv
      - testbench/phoenix_tb.sv

// ==== testbench/phoenix_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

// behavioral parallel-in shift register with bit h on dout after load
module shift_reg_chip (
    input  logic                            load_n,
    input  logic                            clk,
    input  logic [phoenix_pkg::SR_BITS-1:0] pattern,
    output logic                            dout
);

    logic [phoenix_pkg::SR_BITS-1:0] sr = '1;

    always @(posedge clk or negedge load_n) begin
        if (!load_n) begin
            sr <= pattern;
        end else begin
            sr <= {1'b0, sr[phoenix_pkg::SR_BITS-1:1]};
        end
    end

    assign dout = sr[0];

endmodule

module phoenix_tb;

    localparam int CLK_PERIOD        = 40;
    localparam int RESET_CYCLES      = 10;
    localparam int CYCLES_PER_RECORD = 3000;
    localparam int HALL_WAIT         = 100;
    localparam int FILTER_DELAY_MAX  = 130;

    typedef struct packed {
        logic [7:0]  kind;
        logic [31:0] f0;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
    } test_record_t;

    logic CLK25MHz;
    logic rst;
    logic hall1_load_n;
    logic hall1_clk;
    logic hall1_dout;
    logic hall2_load_n;
    logic hall2_clk;
    logic hall2_dout;
    logic gp_stop_n;
    logic mod_sleep_n;
    logic [phoenix_pkg::PWM_MOTORS-1:0] motor_enc_a;
    logic [phoenix_pkg::PWM_MOTORS-1:0] motor_enc_b;
    logic [phoenix_pkg::HALL_MOTORS-1:0] motor_sw_flt_n;
    phoenix_pkg::pwm_cmd_t [phoenix_pkg::PWM_MOTORS-1:0] pwm_cmd;
    logic [phoenix_pkg::PWM_MOTORS-1:0] pwm_valid;
    logic host_wr;
    phoenix_pkg::host_ctrl_t host_ctrl;
    logic [phoenix_pkg::STATUS_WIDTH-1:0] status_word;
    logic [phoenix_pkg::PWM_MOTORS-1:0][2:0] motor_pwm;
    logic [phoenix_pkg::PWM_MOTORS-1:0][2:0] motor_reset_n;
    logic [phoenix_pkg::HALL_MOTORS-1:0] motor_sw_en;
    logic [phoenix_pkg::HALL_MOTORS-1:0] motor_led;
    logic fpga_int;

    logic [phoenix_pkg::SR_BITS-1:0] chip1_pattern;
    logic [phoenix_pkg::SR_BITS-1:0] chip2_pattern;
    test_record_t records[$];
    logic records_loaded;
    logic fault_set;
    int checks;
    int errors;

    phoenix_top UUT (.*);

    shift_reg_chip hall_chip_1_model (
        .load_n  (hall1_load_n),
        .clk     (hall1_clk),
        .pattern (chip1_pattern),
        .dout    (hall1_dout)
    );

    shift_reg_chip hall_chip_2_model (
        .load_n  (hall2_load_n),
        .clk     (hall2_clk),
        .pattern (chip2_pattern),
        .dout    (hall2_dout)
    );

    initial begin
        CLK25MHz = 1'b0;
        forever #(CLK_PERIOD / 2) CLK25MHz = ~CLK25MHz;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // chip bit order is h g f e d c b a ser with h at index 0
    function automatic logic [31:0] expected_status();
        logic [8:0] b1;
        logic [8:0] b2;
        logic [2:0] uvw [5];
        logic [31:0] word;
        b1 = ~chip1_pattern;
        b2 = ~chip2_pattern;
        uvw[0] = {b1[1], b1[2], b1[3]};
        uvw[1] = {b1[5], b1[6], b1[7]};
        uvw[2] = {b2[1], b2[2], b2[3]};
        uvw[3] = {b2[4], b2[5], b2[6]};
        uvw[4] = {b2[8], b2[7], b2[0]};
        word = '0;
        word[1:0] = 2'b11;
        word[6:2] = motor_sw_flt_n;
        for (int m = 0; m < 4; m++) begin
            word[8 + 5 * m]     = uvw[m][2];
            word[8 + 5 * m + 1] = uvw[m][1];
            word[8 + 5 * m + 2] = uvw[m][0];
            word[8 + 5 * m + 3] = motor_enc_a[m];
            word[8 + 5 * m + 4] = motor_enc_b[m];
        end
        word[30:28] = {uvw[4][0], uvw[4][1], uvw[4][2]};
        return word;
    endfunction

    task automatic read_test_records(input int fd);
        int code;
        int ch;
        logic done;
        logic [7:0] kind;
        logic [31:0] f [4];
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, " %c", kind);
            f[0] = 0;
            f[1] = 0;
            f[2] = 0;
            f[3] = 0;
            if (code != 1) begin
                done = 1'b1;
            end else if (kind == "#") begin
                ch = $fgetc(fd);
                while (ch != "\n" && ch != -1) ch = $fgetc(fd);
            end else begin
                case (kind)
                    "H": code = $fscanf(fd, "%h %h", f[0], f[1]);
                    "E": code = $fscanf(fd, "%h %h %h", f[0], f[1], f[2]);
                    "G": code = $fscanf(fd, "%d %d", f[0], f[1]);
                    "C": code = $fscanf(fd, "%h", f[0]);
                    "P": code = $fscanf(fd, "%d %h %h %h", f[0], f[1], f[2], f[3]);
                    default: code = 0;
                endcase
                assert (code > 0) else begin
                    errors++;
                    $display("test record of type %c could not be read", kind);
                end
                if (code > 0) records.push_back('{kind, f[0], f[1], f[2], f[3]});
            end
        end
    endtask

    task automatic verify_hall_mapping(input logic [8:0] p1, input logic [8:0] p2);
        @(negedge CLK25MHz);
        chip1_pattern = p1;
        chip2_pattern = p2;
        repeat (HALL_WAIT) @(negedge CLK25MHz);
        check_value("status_word", status_word, expected_status());
    endtask

    task automatic drive_enc_levels(input logic [3:0] a, input logic [3:0] b,
                                    input logic [4:0] flt_n);
        @(negedge CLK25MHz);
        motor_enc_a    = a;
        motor_enc_b    = b;
        motor_sw_flt_n = flt_n;
        repeat (3) @(negedge CLK25MHz);
        check_value("status_word", status_word, expected_status());
    endtask

    // low pulse of len cycles on stop or sleep and a wait for the filter to settle
    task automatic pulse_filter_input(input logic sleep, input int len);
        int i;
        int first_low;
        int wait_cnt;
        int bit_idx;
        string name;
        bit_idx = sleep ? 1 : 0;
        name = sleep ? "mod_sleep_n" : "gp_stop_n";
        first_low = -1;
        for (i = 0; i < len + FILTER_DELAY_MAX; i++) begin
            @(negedge CLK25MHz);
            if (first_low < 0 && !status_word[bit_idx]) first_low = i;
            if (sleep) begin
                mod_sleep_n = (i >= len);
            end else begin
                gp_stop_n = (i >= len);
            end
        end
        check_value($sformatf("%s filtered low seen", name), first_low >= 0,
                    len >= phoenix_pkg::DEGLITCH_COUNT);
        assert (first_low <= FILTER_DELAY_MAX) else begin
            errors++;
            $display("%s filter took %0d cycles to go low", name, first_low);
        end
        wait_cnt = 0;
        while (!status_word[bit_idx] && wait_cnt < 2 * phoenix_pkg::DEGLITCH_COUNT) begin
            @(negedge CLK25MHz);
            wait_cnt++;
        end
        assert (status_word[bit_idx]) else begin
            errors++;
            $display("%s filter did not return high after the pulse", name);
        end
    endtask

    task automatic write_control(input logic [11:0] word);
        phoenix_pkg::host_ctrl_t exp;
        logic was_fault;
        logic [11:0] pwm_seen;
        logic [11:0] rst_seen;
        exp = word;
        was_fault = fault_set;
        @(negedge CLK25MHz);
        host_ctrl = exp;
        host_wr   = 1'b1;
        @(negedge CLK25MHz);
        host_wr = 1'b0;
        check_value("motor_sw_en", motor_sw_en, exp.sw_en);
        check_value("motor_led", motor_led, exp.led);
        check_value("fpga_int", fpga_int, exp.fpga_int);
        fault_set = exp.fault;
        if (exp.fault) begin
            @(negedge CLK25MHz);
            check_value("motor_pwm", motor_pwm, '0);
            check_value("motor_reset_n", motor_reset_n, '0);
        end else if (was_fault) begin
            // drivers stay off until a new command
            pwm_seen = '0;
            rst_seen = '0;
            repeat (2 * phoenix_pkg::PWM_PERIOD) begin
                @(negedge CLK25MHz);
                pwm_seen |= motor_pwm;
                rst_seen |= motor_reset_n;
            end
            check_value("motor_pwm after fault clear", pwm_seen, '0);
            check_value("motor_reset_n after fault clear", rst_seen, '0);
        end
    endtask

    task automatic measure_pwm_on_time(input int m, input logic [15:0] da,
                                       input logic [15:0] db, input logic [15:0] dc);
        phoenix_pkg::pwm_cmd_t cmd;
        logic [15:0] duty [3];
        int on_cnt [3];
        int exp_on;
        int p;
        cmd.duty_a = da;
        cmd.duty_b = db;
        cmd.duty_c = dc;
        duty[0] = da;
        duty[1] = db;
        duty[2] = dc;
        @(negedge CLK25MHz);
        pwm_cmd[m]   = cmd;
        pwm_valid[m] = 1'b1;
        @(negedge CLK25MHz);
        pwm_valid = '0;
        repeat (2 * phoenix_pkg::PWM_PERIOD) @(negedge CLK25MHz);
        for (p = 0; p < 3; p++) on_cnt[p] = 0;
        repeat (phoenix_pkg::PWM_PERIOD) begin
            @(negedge CLK25MHz);
            for (p = 0; p < 3; p++) on_cnt[p] = on_cnt[p] + motor_pwm[m][p];
        end
        for (p = 0; p < 3; p++) begin
            exp_on = int'(duty[p]) < phoenix_pkg::PWM_MAX_ON ? int'(duty[p])
                                                              : phoenix_pkg::PWM_MAX_ON;
            if (fault_set) exp_on = 0;
            check_value($sformatf("motor_pwm[%0d][%0d] high cycles", m, p), on_cnt[p], exp_on);
        end
        check_value($sformatf("motor_reset_n[%0d]", m), motor_reset_n[m],
                    fault_set ? 3'b000 : 3'b111);
    endtask

    initial begin
        int fd;
        rst            = 1'b1;
        gp_stop_n      = 1'b1;
        mod_sleep_n    = 1'b1;
        motor_enc_a    = '0;
        motor_enc_b    = '0;
        motor_sw_flt_n = '1;
        pwm_cmd        = '0;
        pwm_valid      = '0;
        host_wr        = 1'b0;
        host_ctrl      = '0;
        chip1_pattern  = '1;
        chip2_pattern  = '1;
        records_loaded = 1'b0;
        fault_set      = 1'b1;
        checks         = 0;
        errors         = 0;

        fd = $fopen("testbench/phoenix_tests.txt", "r");
        assert (fd != 0) else begin
            errors++;
            $display("test data file testbench/phoenix_tests.txt could not be opened");
        end
        if (fd != 0) begin
            read_test_records(fd);
            $fclose(fd);
        end
        records_loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge CLK25MHz);
        @(negedge CLK25MHz);
        rst = 1'b0;
        repeat (2) @(negedge CLK25MHz);
        check_value("status_word[1:0]", status_word[1:0], 2'b11);
        check_value("motor_pwm", motor_pwm, '0);
        check_value("motor_reset_n", motor_reset_n, '0);
        check_value("motor_sw_en", motor_sw_en, '0);
        check_value("motor_led", motor_led, '0);
        check_value("fpga_int", fpga_int, 1'b0);

        foreach (records[i]) begin
            case (records[i].kind)
                "H": verify_hall_mapping(records[i].f0[8:0], records[i].f1[8:0]);
                "E": drive_enc_levels(records[i].f0[3:0], records[i].f1[3:0],
                                      records[i].f2[4:0]);
                "G": begin
                    pulse_filter_input(1'b0, records[i].f0);
                    pulse_filter_input(1'b1, records[i].f1);
                end
                "C": write_control(records[i].f0[11:0]);
                default: measure_pwm_on_time(records[i].f0, records[i].f1[15:0],
                                             records[i].f2[15:0], records[i].f3[15:0]);
            endcase
        end

        $display("%0d records, %0d checks, %0d errors", records.size(), checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // watchdog scaled to the number of test records
    initial begin
        wait (records_loaded);
        repeat (records.size() * CYCLES_PER_RECORD) @(posedge CLK25MHz);
        $display("watchdog expired before the tests completed");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/phoenix_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

module phoenix_assert (
    input logic                                    CLK25MHz,
    input logic                                    rst,
    input logic                                    fault,
    input logic [phoenix_pkg::PWM_MOTORS-1:0][2:0] motor_pwm,
    input logic [phoenix_pkg::PWM_MOTORS-1:0][2:0] motor_reset_n,
    input logic                                    hall1_load_n,
    input logic                                    hall1_clk,
    input logic                                    hall2_load_n,
    input logic                                    hall2_clk
);

    // fault stops every phase on the next cycle
    fault_stops_pwm: assert property (@(posedge CLK25MHz) disable iff (rst)
        fault |=> motor_pwm == '0)
        else $error("phases still driven one cycle after fault");

    no_pwm_in_reset: assert property (@(posedge CLK25MHz) disable iff (rst)
        (motor_pwm & ~motor_reset_n) == '0)
        else $error("phase high while its driver is held in reset");

    // chip clock stays low during parallel load
    load_keeps_clk_low: assert property (@(posedge CLK25MHz) disable iff (rst)
        (hall1_load_n || !hall1_clk) && (hall2_load_n || !hall2_clk))
        else $error("shift clock high while load_n is low");

endmodule

bind phoenix_top phoenix_assert phoenix_checks (
    .CLK25MHz      (CLK25MHz),
    .rst           (rst),
    .fault         (ctrl.fault),
    .motor_pwm     (motor_pwm),
    .motor_reset_n (motor_reset_n),
    .hall1_load_n  (hall1_load_n),
    .hall1_clk     (hall1_clk),
    .hall2_load_n  (hall2_load_n),
    .hall2_clk     (hall2_clk)
);

`default_nettype wire

// ==== hw/phoenix_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module phoenix_top (
    input  logic                                                CLK25MHz,
    input  logic                                                rst,
    output logic                                                hall1_load_n,
    output logic                                                hall1_clk,
    input  logic                                                hall1_dout,
    output logic                                                hall2_load_n,
    output logic                                                hall2_clk,
    input  logic                                                hall2_dout,
    input  logic                                                gp_stop_n,
    input  logic                                                mod_sleep_n,
    input  logic [phoenix_pkg::PWM_MOTORS-1:0]                  motor_enc_a,
    input  logic [phoenix_pkg::PWM_MOTORS-1:0]                  motor_enc_b,
    input  logic [phoenix_pkg::HALL_MOTORS-1:0]                 motor_sw_flt_n,
    input  phoenix_pkg::pwm_cmd_t [phoenix_pkg::PWM_MOTORS-1:0] pwm_cmd,
    input  logic [phoenix_pkg::PWM_MOTORS-1:0]                  pwm_valid,
    input  logic                                                host_wr,
    input  phoenix_pkg::host_ctrl_t                             host_ctrl,
    output logic [phoenix_pkg::STATUS_WIDTH-1:0]                status_word,
    output logic [phoenix_pkg::PWM_MOTORS-1:0][2:0]             motor_pwm,
    output logic [phoenix_pkg::PWM_MOTORS-1:0][2:0]             motor_reset_n,
    output logic [phoenix_pkg::HALL_MOTORS-1:0]                 motor_sw_en,
    output logic [phoenix_pkg::HALL_MOTORS-1:0]                 motor_led,
    output logic                                                fpga_int
);

    logic [phoenix_pkg::SR_BITS-1:0] chip1_bits;
    logic [phoenix_pkg::SR_BITS-1:0] chip2_bits;
    logic chip1_valid;
    logic chip2_valid;
    logic gp_stop_filt_n;
    logic mod_sleep_filt_n;
    phoenix_pkg::hall_bank_t hall_bank;
    phoenix_pkg::host_ctrl_t ctrl;

    hall_sr_reader hall_chip_1 (
        .CLK25MHz   (CLK25MHz),
        .rst        (rst),
        .sr_dout    (hall1_dout),
        .sr_load_n  (hall1_load_n),
        .sr_clk     (hall1_clk),
        .bits       (chip1_bits),
        .bits_valid (chip1_valid)
    );

    hall_sr_reader hall_chip_2 (
        .CLK25MHz   (CLK25MHz),
        .rst        (rst),
        .sr_dout    (hall2_dout),
        .sr_load_n  (hall2_load_n),
        .sr_clk     (hall2_clk),
        .bits       (chip2_bits),
        .bits_valid (chip2_valid)
    );

    // chip bit index h=0 g=1 f=2 e=3 d=4 c=5 b=6 a=7 ser=8
    always_ff @(posedge CLK25MHz) begin
        if (rst) begin
            hall_bank <= '0;
        end else begin
            if (chip1_valid) begin
                hall_bank[0] <= '{u: chip1_bits[1], v: chip1_bits[2], w: chip1_bits[3]};
                hall_bank[1] <= '{u: chip1_bits[5], v: chip1_bits[6], w: chip1_bits[7]};
            end
            if (chip2_valid) begin
                hall_bank[2] <= '{u: chip2_bits[1], v: chip2_bits[2], w: chip2_bits[3]};
                hall_bank[3] <= '{u: chip2_bits[4], v: chip2_bits[5], w: chip2_bits[6]};
                // motor 5 spans ser, a and h
                hall_bank[4] <= '{u: chip2_bits[8], v: chip2_bits[7], w: chip2_bits[0]};
            end
        end
    end

    input_deglitch stop_filter (
        .CLK25MHz (CLK25MHz),
        .rst      (rst),
        .raw      (gp_stop_n),
        .filtered (gp_stop_filt_n)
    );

    input_deglitch sleep_filter (
        .CLK25MHz (CLK25MHz),
        .rst      (rst),
        .raw      (mod_sleep_n),
        .filtered (mod_sleep_filt_n)
    );

    for (genvar i = 0; i < phoenix_pkg::PWM_MOTORS; i++) begin : g_pwm
        pwm_phase_driver pwm_driver (
            .CLK25MHz       (CLK25MHz),
            .rst            (rst),
            .fault          (ctrl.fault),
            .cmd            (pwm_cmd[i]),
            .cmd_valid      (pwm_valid[i]),
            .pwm            (motor_pwm[i]),
            .driver_reset_n (motor_reset_n[i])
        );
    end

    board_io_regs io_regs (
        .CLK25MHz         (CLK25MHz),
        .rst              (rst),
        .host_wr          (host_wr),
        .host_ctrl        (host_ctrl),
        .hall             (hall_bank),
        .gp_stop_filt_n   (gp_stop_filt_n),
        .mod_sleep_filt_n (mod_sleep_filt_n),
        .enc_a            (motor_enc_a),
        .enc_b            (motor_enc_b),
        .sw_flt_n         (motor_sw_flt_n),
        .ctrl             (ctrl),
        .status_word      (status_word)
    );

    assign motor_sw_en = ctrl.sw_en;
    assign motor_led   = ctrl.led;
    assign fpga_int    = ctrl.fpga_int;

endmodule

`default_nettype wire

// ==== hw/board_io_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module board_io_regs (
    input  logic                                 CLK25MHz,
    input  logic                                 rst,
    input  logic                                 host_wr,
    input  phoenix_pkg::host_ctrl_t              host_ctrl,
    input  phoenix_pkg::hall_bank_t              hall,
    input  logic                                 gp_stop_filt_n,
    input  logic                                 mod_sleep_filt_n,
    input  logic [phoenix_pkg::PWM_MOTORS-1:0]   enc_a,
    input  logic [phoenix_pkg::PWM_MOTORS-1:0]   enc_b,
    input  logic [phoenix_pkg::HALL_MOTORS-1:0]  sw_flt_n,
    output phoenix_pkg::host_ctrl_t              ctrl,
    output logic [phoenix_pkg::STATUS_WIDTH-1:0] status_word
);

    logic [phoenix_pkg::STATUS_WIDTH-1:0] status_next;

    // motors stay in fault until the host clears it
    always_ff @(posedge CLK25MHz) begin
        if (rst) begin
            ctrl       <= '0;
            ctrl.fault <= 1'b1;
        end else if (host_wr) begin
            ctrl <= host_ctrl;
        end
    end

    always_comb begin
        status_next      = '0;
        status_next[0]   = gp_stop_filt_n;
        status_next[1]   = mod_sleep_filt_n;
        status_next[6:2] = sw_flt_n;
        // five bits per wheel motor with u at the lowest bit
        for (int m = 0; m < phoenix_pkg::PWM_MOTORS; m++) begin
            status_next[8 + 5 * m +: 5] = {enc_b[m], enc_a[m], hall[m].w, hall[m].v, hall[m].u};
        end
        status_next[30:28] = {hall[phoenix_pkg::HALL_MOTORS-1].w,
                              hall[phoenix_pkg::HALL_MOTORS-1].v,
                              hall[phoenix_pkg::HALL_MOTORS-1].u};
    end

    always_ff @(posedge CLK25MHz) begin
        status_word <= status_next;
    end

endmodule

`default_nettype wire

// ==== hw/pwm_phase_driver.sv ====
`timescale 1ns/10ps
`default_nettype none

module pwm_phase_driver (
    input  logic                  CLK25MHz,
    input  logic                  rst,
    input  logic                  fault,
    input  phoenix_pkg::pwm_cmd_t cmd,
    input  logic                  cmd_valid,
    output logic [2:0]            pwm,
    output logic [2:0]            driver_reset_n
);

    phoenix_pkg::pwm_cmd_t pending;
    phoenix_pkg::pwm_cmd_t active;
    logic [2:0][phoenix_pkg::DUTY_WIDTH-1:0] active_duty;
    logic [$clog2(phoenix_pkg::PWM_PERIOD)-1:0] period_cnt;
    logic period_wrap;
    logic armed;

    assign period_wrap = int'(period_cnt) == phoenix_pkg::PWM_PERIOD - 1;

    // phase a at index 0
    assign active_duty = {active.duty_c, active.duty_b, active.duty_a};

    always_ff @(posedge CLK25MHz) begin
        if (rst) begin
            period_cnt <= '0;
        end else if (period_wrap) begin
            period_cnt <= '0;
        end else begin
            period_cnt <= period_cnt + 1'b1;
        end
    end

    // a fault throws away both duties and disarms the driver
    always_ff @(posedge CLK25MHz) begin
        if (rst || fault) begin
            pending        <= '0;
            active         <= '0;
            armed          <= 1'b0;
            driver_reset_n <= '0;
        end else begin
            if (cmd_valid) begin
                pending <= cmd;
                armed   <= 1'b1;
            end
            if (period_wrap) begin
                active <= pending;
                if (armed) begin
                    driver_reset_n <= '1;
                end
            end
        end
    end

    // on time is min(duty, PWM_MAX_ON)
    always_ff @(posedge CLK25MHz) begin
        if (rst || fault) begin
            pwm <= '0;
        end else begin
            for (int p = 0; p < 3; p++) begin
                pwm[p] <= (int'(period_cnt) < int'(active_duty[p]))
                          && (int'(period_cnt) < phoenix_pkg::PWM_MAX_ON);
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/input_deglitch.sv ====
`timescale 1ns/10ps
`default_nettype none

module input_deglitch (
    input  logic CLK25MHz,
    input  logic rst,
    input  logic raw,
    output logic filtered
);

    logic [1:0] raw_sync;
    logic [$clog2(phoenix_pkg::DEGLITCH_COUNT)-1:0] run_cnt;

    always_ff @(posedge CLK25MHz) begin
        if (rst) begin
            raw_sync <= 2'b11;
            run_cnt  <= '0;
            filtered <= 1'b1;
        end else begin
            // two flops for the asynchronous board input
            raw_sync <= {raw_sync[0], raw};
            if (raw_sync[1] == filtered) begin
                run_cnt <= '0;
            end else if (int'(run_cnt) == phoenix_pkg::DEGLITCH_COUNT - 1) begin
                run_cnt  <= '0;
                filtered <= raw_sync[1];
            end else begin
                run_cnt <= run_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/hall_sr_reader.sv ====
`timescale 1ns/10ps
`default_nettype none

module hall_sr_reader (
    input  logic                            CLK25MHz,
    input  logic                            rst,
    input  logic                            sr_dout,
    output logic                            sr_load_n,
    output logic                            sr_clk,
    output logic [phoenix_pkg::SR_BITS-1:0] bits,
    output logic                            bits_valid
);

    phoenix_pkg::sr_state_e state;
    logic [$clog2(phoenix_pkg::SR_BITS)-1:0] bit_cnt;
    logic [phoenix_pkg::SR_BITS-1:0] shift_reg;
    logic last_bit;

    assign last_bit = int'(bit_cnt) == phoenix_pkg::SR_BITS - 1;

    // load and clock outputs are registered along with the state
    always_ff @(posedge CLK25MHz) begin
        if (rst) begin
            state      <= phoenix_pkg::SR_DONE;
            bit_cnt    <= '0;
            sr_load_n  <= 1'b1;
            sr_clk     <= 1'b0;
            bits_valid <= 1'b0;
        end else begin
            sr_load_n  <= 1'b1;
            sr_clk     <= 1'b0;
            bits_valid <= 1'b0;
            case (state)
                phoenix_pkg::SR_LOAD: begin
                    state   <= phoenix_pkg::SR_SHIFT_LOW;
                    bit_cnt <= '0;
                end
                phoenix_pkg::SR_SHIFT_LOW: begin
                    // rising sr_clk shifts the next bit onto dout
                    state  <= phoenix_pkg::SR_SHIFT_HIGH;
                    sr_clk <= 1'b1;
                end
                phoenix_pkg::SR_SHIFT_HIGH: begin
                    if (last_bit) begin
                        state      <= phoenix_pkg::SR_DONE;
                        bits_valid <= 1'b1;
                    end else begin
                        state   <= phoenix_pkg::SR_SHIFT_LOW;
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                phoenix_pkg::SR_DONE: begin
                    state     <= phoenix_pkg::SR_LOAD;
                    sr_load_n <= 1'b0;
                end
            endcase
        end
    end

    // h arrives first and ends up at index 0
    always_ff @(posedge CLK25MHz) begin
        if (state == phoenix_pkg::SR_SHIFT_LOW) begin
            shift_reg <= {sr_dout, shift_reg[phoenix_pkg::SR_BITS-1:1]};
        end
        if (state == phoenix_pkg::SR_SHIFT_HIGH && last_bit) begin
            // hall sensors are active low on the chip inputs
            bits <= ~shift_reg;
        end
    end

endmodule

`default_nettype wire

// ==== hw/phoenix_pkg.sv ====
`default_nettype none

package phoenix_pkg;

    // eight parallel hall bits plus the serial input
    localparam int SR_BITS = 9;

    // cycles a new input level has to hold
    localparam int DEGLITCH_COUNT = 125;

    // pwm timing in CLK25MHz cycles
    localparam int PWM_PERIOD = 250;
    localparam int PWM_MAX_ON = 245;

    localparam int PWM_MOTORS   = 4;
    localparam int HALL_MOTORS  = 5;
    localparam int DUTY_WIDTH   = 16;
    localparam int STATUS_WIDTH = 32;

    typedef struct packed {
        logic u;
        logic v;
        logic w;
    } hall_uvw_t;

    // index 0 is motor 1
    typedef hall_uvw_t [HALL_MOTORS-1:0] hall_bank_t;

    typedef struct packed {
        logic [DUTY_WIDTH-1:0] duty_a;
        logic [DUTY_WIDTH-1:0] duty_b;
        logic [DUTY_WIDTH-1:0] duty_c;
    } pwm_cmd_t;

    typedef struct packed {
        logic                   fault;
        logic                   fpga_int;
        logic [HALL_MOTORS-1:0] led;
        logic [HALL_MOTORS-1:0] sw_en;
    } host_ctrl_t;

    typedef enum logic [1:0] {
        SR_LOAD,
        SR_SHIFT_LOW,
        SR_SHIFT_HIGH,
        SR_DONE
    } sr_state_e;

endpackage

`default_nettype wire
